/* list.f */
rtl/au_pkg.sv
rtl/au_rf_if.sv
rtl/au_regfile.sv
rtl/au_core.sv
rtl/au_issue.sv
rtl/au_wb_host.sv
rtl/au_cluster_top.sv
sim/tb_clock.sv
sim/au_properties.sv
sim/tb_au_cluster.sv

/* rtl/au_cluster_top.sv */
`timescale 1ns/10ps

module au_cluster_top
(
  input  logic             CLK,
  input  logic             RST,
  input  logic             CYC,
  input  logic             STB,
  input  logic             WE,
  input  au_pkg::wb_addr_t ADR,
  input  au_pkg::word_t    DAT_W,
  output au_pkg::word_t    DAT_R,
  output logic             ACK
);

  logic              slot_wr;
  au_pkg::slice_t    slot_idx;
  au_pkg::au_op_t    slot_op;
  logic [3:0]        slot_busy;
  au_pkg::slice_t    slice;
  logic              op_vld;
  au_pkg::au_op_t    op;
  logic              host_we;
  au_pkg::slice_t    host_slice;
  au_pkg::reg_addr_t host_addr;
  au_pkg::word_t     host_wdata;
  au_pkg::word_t     host_rdata;
  au_pkg::slice_t    flag_slice;
  au_pkg::au_flags_t flags;

  au_rf_if rf_bus ();

  au_wb_host wb_host_inst (
    .CLK        (CLK),
    .RST        (RST),
    .wb_cyc     (CYC),
    .wb_stb     (STB),
    .wb_we      (WE),
    .wb_adr     (ADR),
    .wb_dat_w   (DAT_W),
    .wb_dat_r   (DAT_R),
    .wb_ack     (ACK),
    .slot_wr    (slot_wr),
    .slot_idx   (slot_idx),
    .slot_op    (slot_op),
    .slot_busy  (slot_busy),
    .host_we    (host_we),
    .host_slice (host_slice),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .flag_slice (flag_slice),
    .flags      (flags),
    .rc_vld     (rf_bus.rc_vld)
  );

  au_issue issue_inst (
    .CLK       (CLK),
    .RST       (RST),
    .slot_wr   (slot_wr),
    .slot_idx  (slot_idx),
    .slot_op   (slot_op),
    .slot_busy (slot_busy),
    .slice     (slice),
    .op_vld    (op_vld),
    .op        (op)
  );

  au_core core_inst (
    .CLK        (CLK),
    .RST        (RST),
    .slice      (slice),
    .op_vld     (op_vld),
    .op         (op),
    .rf         (rf_bus),
    .flag_slice (flag_slice),
    .flags      (flags)
  );

  au_regfile regfile_inst (
    .CLK        (CLK),
    .RST        (RST),
    .rf         (rf_bus),
    .slice      (slice),
    .host_we    (host_we),
    .host_slice (host_slice),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata)
  );

endmodule

/* rtl/au_core.sv */
`timescale 1ns/10ps

module au_core
(
  input  logic              CLK,
  input  logic              RST,
  input  au_pkg::slice_t    slice,
  input  logic              op_vld,
  input  au_pkg::au_op_t    op,
  au_rf_if.core             rf,
  input  au_pkg::slice_t    flag_slice,
  output au_pkg::au_flags_t flags
);

  function automatic logic [32:0] ext33(input au_pkg::word_t w);
    return {w[31], w};
  endfunction

  // Stage 0, decode in the issue cycle
  au_pkg::op_class_e cls;
  logic              short_form;
  logic [3:0]        tw_cmd;
  logic [2:0]        bop_cmd;
  logic [4:0]        bop_idx;
  au_pkg::word_t     imm;
  au_pkg::reg_addr_t rc_sel_s0;
  logic              wb_s0;

  assign cls = op[14] ? au_pkg::op_class_e'({op[14:13], 1'b0})
                      : au_pkg::op_class_e'(op[14:12]);
  assign short_form = (cls == au_pkg::cls_short);

  assign tw_cmd  = short_form ? {1'b0, op[11:9]} : op[11:8];
  assign bop_cmd = op[11:9];
  assign bop_idx = op[8:4];
  assign imm     = op[14] ? {{23{op[12]}}, op[12:4]} : {{24{op[11]}}, op[11:4]};

  assign rf.ra_sel = short_form ? {1'b0, op[2:0]} : op[3:0];
  assign rf.rb_sel = short_form ? {1'b0, op[5:3]} : op[7:4];
  assign rc_sel_s0 = short_form ? {1'b0, op[8:6]} : op[3:0];

  // Compares and bit tests only touch the flags
  always_comb
  begin
    case (cls)
      au_pkg::cls_long, au_pkg::cls_short: wb_s0 = (tw_cmd != au_pkg::cmd_cmp);
      au_pkg::cls_bitop:                   wb_s0 = (bop_cmd != au_pkg::bit_tst);
      au_pkg::cls_cmpi:                    wb_s0 = 1'b0;
      default:                             wb_s0 = 1'b1;
    endcase
  end

  // Stage 1, operands registered
  logic              vld_q;
  logic              wb_q;
  au_pkg::word_t     a_q;
  au_pkg::word_t     b_q;
  logic [3:0]        cmd_q;
  au_pkg::op_class_e cls_q;
  au_pkg::reg_addr_t sel_q;
  au_pkg::slice_t    slice_q;

  always_ff @(posedge CLK)
  begin
    if (op_vld)
    begin
      a_q     <= rf.ra;
      cls_q   <= cls;
      sel_q   <= rc_sel_s0;
      slice_q <= slice;
      // Immediate or bit index takes the place of B
      if (cls == au_pkg::cls_bitop)
      begin
        b_q   <= {27'd0, bop_idx};
        cmd_q <= {1'b0, bop_cmd};
      end
      else
      begin
        b_q   <= (op[14] || cls == au_pkg::cls_addi) ? imm : rf.rb;
        cmd_q <= tw_cmd;
      end
    end
  end

  // Result units, evaluated in T+1
  logic [32:0] a_ext;
  logic [32:0] b_ext;
  logic [32:0] tw_res;
  logic [32:0] bit_res;
  logic [32:0] imm_res;
  logic [32:0] result;
  logic [4:0]  idx;
  logic [31:0] hi_mask;
  logic [31:0] one_hot;

  assign a_ext   = ext33(a_q);
  assign b_ext   = ext33(b_q);
  assign idx     = b_q[4:0];
  assign hi_mask = 32'hFFFF_FFFF << idx;
  assign one_hot = 32'd1 << idx;

  // Logic results are sign-extended so only true arithmetic can overflow
  always_comb
  begin
    case (cmd_q)
      au_pkg::cmd_or:  tw_res = ext33(a_q | b_q);
      au_pkg::cmd_and: tw_res = ext33(a_q & b_q);
      au_pkg::cmd_xor: tw_res = ext33(a_q ^ b_q);
      au_pkg::cmd_add: tw_res = a_ext + b_ext;
      au_pkg::cmd_sub: tw_res = a_ext - b_ext;
      au_pkg::cmd_mov: tw_res = b_ext;
      au_pkg::cmd_not: tw_res = ~b_ext;
      au_pkg::cmd_neg: tw_res = 33'd0 - b_ext;
      au_pkg::cmd_cmp: tw_res = a_ext - b_ext;
      default:         tw_res = 33'd0;
    endcase
  end

  always_comb
  begin
    case (cmd_q[2:0])
      au_pkg::bit_set:  bit_res = ext33(a_q | one_hot);
      au_pkg::bit_clr:  bit_res = ext33(a_q & ~one_hot);
      au_pkg::bit_tst:  bit_res = ext33(a_q & one_hot);
      au_pkg::bit_shl:  bit_res = ext33(a_q << idx);
      au_pkg::bit_shr:  bit_res = ext33(a_q >> idx);
      au_pkg::bit_asr:  bit_res = ext33($signed(a_q) >>> idx);
      // Copy the chosen bit into every bit above it
      au_pkg::bit_sext: bit_res = ext33(a_q[idx] ? (a_q | hi_mask) : (a_q & ~hi_mask));
      default:          bit_res = 33'd0;
    endcase
  end

  always_comb
  begin
    case (cls_q)
      au_pkg::cls_addi: imm_res = a_ext + b_ext;
      au_pkg::cls_cmpi: imm_res = a_ext - b_ext;
      au_pkg::cls_ldi:  imm_res = b_ext;
      default:          imm_res = 33'd0;
    endcase
  end

  always_comb
  begin
    case (cls_q)
      au_pkg::cls_bitop:                                 result = bit_res;
      au_pkg::cls_addi, au_pkg::cls_cmpi, au_pkg::cls_ldi: result = imm_res;
      default:                                           result = tw_res;
    endcase
  end

  // Stage 2, result registered at the end of T+1
  logic              vld2;
  logic              wb2;
  logic [32:0]       res_q;
  au_pkg::reg_addr_t sel2;
  au_pkg::slice_t    slice2;

  always_ff @(posedge CLK)
  begin
    if (vld_q)
    begin
      res_q  <= result;
      sel2   <= sel_q;
      slice2 <= slice_q;
    end
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      vld_q <= 1'b0;
      wb_q  <= 1'b0;
      vld2  <= 1'b0;
      wb2   <= 1'b0;
    end
    else
    begin
      vld_q <= op_vld;
      wb_q  <= op_vld && wb_s0;
      vld2  <= vld_q;
      wb2   <= wb_q;
    end
  end

  assign rf.rc_vld   = wb2;
  assign rf.rc_sel   = sel2;
  assign rf.rc       = res_q[31:0];
  assign rf.rc_slice = slice2;

  // Flags follow every result, in the bank of the slice that issued it
  au_pkg::au_flags_t flag_bank [au_pkg::num_slices];
  au_pkg::au_flags_t new_flags;

  assign new_flags.zero = (res_q[31:0] == 32'd0);
  assign new_flags.neg  = res_q[31];
  assign new_flags.ovfl = res_q[32] ^ res_q[31];

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < au_pkg::num_slices; i++)
        flag_bank[i] <= '0;
    end
    else if (vld2)
    begin
      flag_bank[slice2] <= new_flags;
    end
  end

  assign flags = flag_bank[flag_slice];

endmodule

/* rtl/au_issue.sv */
`timescale 1ns/10ps

module au_issue
(
  input  logic           CLK,
  input  logic           RST,
  input  logic           slot_wr,
  input  au_pkg::slice_t slot_idx,
  input  au_pkg::au_op_t slot_op,
  output logic [3:0]     slot_busy,
  output au_pkg::slice_t slice,
  output logic           op_vld,
  output au_pkg::au_op_t op
);

  au_pkg::slice_t cnt;
  logic [3:0]     pending;
  au_pkg::au_op_t slot_mem [au_pkg::num_slices];
  logic           slot_take;

  // A full slot ignores the write, the host holds it off
  assign slot_take = slot_wr && !pending[slot_idx];

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      cnt     <= '0;
      pending <= '0;
    end
    else
    begin
      cnt <= cnt + 2'd1;
      // Issue and post never hit the same slot in one cycle
      if (op_vld)
        pending[cnt] <= 1'b0;
      if (slot_take)
        pending[slot_idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (slot_take)
      slot_mem[slot_idx] <= slot_op;
  end

  assign slice     = cnt;
  assign op_vld    = pending[cnt];
  assign op        = slot_mem[cnt];
  assign slot_busy = pending;

endmodule

/* rtl/au_pkg.sv */
package au_pkg;

  // Thread and register file geometry, fixed by the operation encoding
  localparam int num_slices = 4;
  localparam int au_latency = 2;

  typedef logic [1:0]  slice_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] word_t;
  typedef logic [14:0] au_op_t;
  typedef logic [7:0]  wb_addr_t;

  // Class code as formed from op[14:12], with op[12] forced low when op[14] is set
  typedef enum logic [2:0] {
    cls_long  = 3'b000,
    cls_short = 3'b001,
    cls_bitop = 3'b010,
    cls_addi  = 3'b011,
    cls_cmpi  = 3'b100,
    cls_ldi   = 3'b110
  } op_class_e;

  // Short form only reaches codes 0 to 7
  typedef enum logic [3:0] {
    cmd_or  = 4'h0,
    cmd_and = 4'h1,
    cmd_xor = 4'h2,
    cmd_add = 4'h3,
    cmd_sub = 4'h4,
    cmd_mov = 4'h8,
    cmd_not = 4'h9,
    cmd_neg = 4'hA,
    cmd_cmp = 4'hB
  } tworeg_cmd_e;

  typedef enum logic [2:0] {
    bit_set  = 3'd0,
    bit_clr  = 3'd1,
    bit_tst  = 3'd2,
    bit_shl  = 3'd4,
    bit_shr  = 3'd5,
    bit_asr  = 3'd6,
    bit_sext = 3'd7
  } bitop_cmd_e;

  typedef struct packed {
    logic ovfl;
    logic neg;
    logic zero;
  } au_flags_t;

  // Host word address map
  localparam wb_addr_t slot_base = 8'h00;
  localparam wb_addr_t reg_base  = 8'h40;
  localparam wb_addr_t flag_base = 8'h80;

endpackage

/* rtl/au_regfile.sv */
`timescale 1ns/10ps

module au_regfile
(
  input  logic              CLK,
  input  logic              RST,
  au_rf_if.rf               rf,
  input  au_pkg::slice_t    slice,
  input  logic              host_we,
  input  au_pkg::slice_t    host_slice,
  input  au_pkg::reg_addr_t host_addr,
  input  au_pkg::word_t     host_wdata,
  output au_pkg::word_t     host_rdata
);

  // One bank of sixteen words per slice, addressed as {slice, register}
  au_pkg::word_t mem [au_pkg::num_slices * 16];

  logic       wr_en;
  logic [5:0] wr_idx;
  au_pkg::word_t wr_data;

  // Writeback wins, the host only gets idle cycles
  always_comb
  begin
    if (rf.rc_vld)
    begin
      wr_en   = 1'b1;
      wr_idx  = {rf.rc_slice, rf.rc_sel};
      wr_data = rf.rc;
    end
    else
    begin
      wr_en   = host_we;
      wr_idx  = {host_slice, host_addr};
      wr_data = host_wdata;
    end
  end

  // No writes while reset is held
  always_ff @(posedge CLK)
  begin
    if (wr_en && !RST)
      mem[wr_idx] <= wr_data;
  end

  assign rf.ra = mem[{slice, rf.ra_sel}];
  assign rf.rb = mem[{slice, rf.rb_sel}];

  assign host_rdata = mem[{host_slice, host_addr}];

endmodule

/* rtl/au_rf_if.sv */
`timescale 1ns/10ps

interface au_rf_if;

  // Operand read selects, answered from the slice now issuing
  au_pkg::reg_addr_t ra_sel;
  au_pkg::reg_addr_t rb_sel;
  au_pkg::word_t     ra;
  au_pkg::word_t     rb;

  // Writeback, tagged with the slice that issued the operation
  logic              rc_vld;
  au_pkg::reg_addr_t rc_sel;
  au_pkg::word_t     rc;
  au_pkg::slice_t    rc_slice;

  modport core (
    output ra_sel, rb_sel, rc_vld, rc_sel, rc, rc_slice,
    input  ra, rb
  );

  modport rf (
    input  ra_sel, rb_sel, rc_vld, rc_sel, rc, rc_slice,
    output ra, rb
  );

endinterface

/* rtl/au_wb_host.sv */
`timescale 1ns/10ps

module au_wb_host
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  au_pkg::wb_addr_t  wb_adr,
  input  au_pkg::word_t     wb_dat_w,
  output au_pkg::word_t     wb_dat_r,
  output logic              wb_ack,
  output logic              slot_wr,
  output au_pkg::slice_t    slot_idx,
  output au_pkg::au_op_t    slot_op,
  input  logic [3:0]        slot_busy,
  output logic              host_we,
  output au_pkg::slice_t    host_slice,
  output au_pkg::reg_addr_t host_addr,
  output au_pkg::word_t     host_wdata,
  input  au_pkg::word_t     host_rdata,
  output au_pkg::slice_t    flag_slice,
  input  au_pkg::au_flags_t flags,
  input  logic              rc_vld
);

  logic          req;
  logic          slot_hit;
  logic          reg_hit;
  logic          flag_hit;
  logic          done;
  au_pkg::word_t rd_mux;

  // Request is open until its ack cycle
  assign req = wb_cyc && wb_stb && !wb_ack;

  assign slot_hit = (wb_adr[7:2] == au_pkg::slot_base[7:2]);
  assign reg_hit  = (wb_adr[7:6] == au_pkg::reg_base[7:6]);
  assign flag_hit = (wb_adr[7:2] == au_pkg::flag_base[7:2]);

  assign slot_idx   = wb_adr[1:0];
  assign slot_op    = wb_dat_w[14:0];
  assign host_slice = wb_adr[5:4];
  assign host_addr  = wb_adr[3:0];
  assign host_wdata = wb_dat_w;
  assign flag_slice = wb_adr[1:0];

  // Slot posts wait for a free slot, register writes for an idle writeback
  assign slot_wr = req && wb_we && slot_hit && !slot_busy[slot_idx];
  assign host_we = req && wb_we && reg_hit && !rc_vld;

  always_comb
  begin
    if (!wb_we)
      done = req;
    else if (slot_hit)
      done = slot_wr;
    else if (reg_hit)
      done = host_we;
    else
      done = req;
  end

  always_comb
  begin
    if (slot_hit)
      rd_mux = {31'd0, slot_busy[slot_idx]};
    else if (reg_hit)
      rd_mux = host_rdata;
    else if (flag_hit)
      rd_mux = {29'd0, flags};
    else
      rd_mux = 32'd0;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      wb_ack <= 1'b0;
    else
      wb_ack <= done;
  end

  // Read data lands together with ack
  always_ff @(posedge CLK)
  begin
    if (req && !wb_we)
      wb_dat_r <= rd_mux;
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_au_cluster \
  -Mdir obj_dir -o tb_au_cluster
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_au_cluster > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "test failed"
  exit 1
fi

# A run cut short by an assertion never reaches the closing line
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "test did not complete"
  exit 1
fi

echo "test passed"
exit 0

/* sim/au_properties.sv */
`timescale 1ns/10ps

module au_properties
(
  input logic           CLK,
  input logic           RST,
  input logic           cyc,
  input logic           stb,
  input logic           ack,
  input logic           op_vld,
  input au_pkg::slice_t slice,
  input logic           rc_vld,
  input au_pkg::slice_t rc_slice
);

  // ACK is a single-cycle pulse
  ack_single: assert property (@(posedge CLK) disable iff (RST) ack |=> !ack)
    else $error("ACK high in two consecutive cycles");

  ack_in_cycle: assert property (@(posedge CLK) disable iff (RST) ack |-> (cyc && stb))
    else $error("ACK high outside an active bus cycle");

  // Writeback bank must match the slice that issued two cycles before
  wb_has_issue: assert property (@(posedge CLK) disable iff (RST)
    rc_vld |-> ($past(op_vld, au_pkg::au_latency) &&
                ($past(slice, au_pkg::au_latency) == rc_slice)))
    else $error("writeback without a matching issue two cycles earlier");

endmodule

bind au_cluster_top au_properties au_properties_inst (
  .CLK      (CLK),
  .RST      (RST),
  .cyc      (CYC),
  .stb      (STB),
  .ack      (ACK),
  .op_vld   (op_vld),
  .slice    (slice),
  .rc_vld   (rf_bus.rc_vld),
  .rc_slice (rf_bus.rc_slice)
);

/* sim/tb_au_cluster.sv */
`timescale 1ns/10ps

module tb_au_cluster;

  localparam int n_tworeg  = 120;
  localparam int n_bitop   = 96;
  localparam int n_imm     = 48;
  localparam int n_rounds  = 6;
  localparam int total_ops = n_tworeg + n_bitop + n_imm + 6 * n_rounds;
  localparam int wd_cycles = 200 * total_ops + 2000;

  typedef struct packed {
    logic              wb;
    au_pkg::reg_addr_t dst;
    au_pkg::word_t     val;
    au_pkg::au_flags_t flg;
  } ref_res_t;

  logic             CLK;
  logic             RST;
  logic             cyc;
  logic             stb;
  logic             we;
  au_pkg::wb_addr_t adr;
  au_pkg::word_t    dat_w;
  au_pkg::word_t    dat_r;
  logic             ack;

  int mismatch_count = 0;
  int other_errors = 0;

  // Reference state, sequential execution per slice
  au_pkg::word_t     ref_regs [au_pkg::num_slices][16];
  au_pkg::au_flags_t ref_flags [au_pkg::num_slices];

  // Expected read results, consumed by the compare process in order
  string         exp_name [$];
  au_pkg::word_t exp_data [$];
  bit            exp_is_flags [$];
  string         cur_name;
  au_pkg::word_t cur_data;
  bit            cur_is_flags;

  tb_clock clock_inst (.CLK(CLK));

  au_cluster_top au_cluster_top_inst (
    .CLK   (CLK),
    .RST   (RST),
    .CYC   (cyc),
    .STB   (stb),
    .WE    (we),
    .ADR   (adr),
    .DAT_W (dat_w),
    .DAT_R (dat_r),
    .ACK   (ack)
  );

  function automatic ref_res_t ref_exec(input au_pkg::slice_t s, input au_pkg::au_op_t op);
    ref_res_t      res;
    au_pkg::word_t a;
    au_pkg::word_t b;
    au_pkg::word_t w;
    logic          ov;
    logic          do_add;
    logic          do_sub;
    logic [3:0]    cmd;
    logic [4:0]    n;
    logic [4:0]    m;
    res     = '0;
    res.wb  = 1'b1;
    res.dst = op[3:0];
    a       = ref_regs[s][op[3:0]];
    b       = 32'd0;
    w       = 32'd0;
    ov      = 1'b0;
    do_add  = 1'b0;
    do_sub  = 1'b0;
    n       = op[8:4];
    m       = 5'd31 - n;
    if (op[14:13] == 2'b00)
    begin
      if (op[12])
      begin
        cmd     = {1'b0, op[11:9]};
        res.dst = {1'b0, op[8:6]};
        a       = ref_regs[s][{1'b0, op[2:0]}];
        b       = ref_regs[s][{1'b0, op[5:3]}];
      end
      else
      begin
        cmd = op[11:8];
        b   = ref_regs[s][op[7:4]];
      end
      case (cmd)
        au_pkg::cmd_or:  w = a | b;
        au_pkg::cmd_and: w = a & b;
        au_pkg::cmd_xor: w = a ^ b;
        au_pkg::cmd_add: do_add = 1'b1;
        au_pkg::cmd_sub: do_sub = 1'b1;
        au_pkg::cmd_mov: w = b;
        au_pkg::cmd_not: w = ~b;
        au_pkg::cmd_neg:
        begin
          w  = 32'd0 - b;
          ov = (b == 32'h8000_0000);
        end
        au_pkg::cmd_cmp:
        begin
          do_sub = 1'b1;
          res.wb = 1'b0;
        end
        default: w = 32'd0;
      endcase
    end
    else if (op[14:12] == 3'b010)
    begin
      case (op[11:9])
        au_pkg::bit_set: w = a | (32'd1 << n);
        au_pkg::bit_clr: w = a & ~(32'd1 << n);
        au_pkg::bit_tst:
        begin
          w      = a & (32'd1 << n);
          res.wb = 1'b0;
        end
        au_pkg::bit_shl:  w = a << n;
        au_pkg::bit_shr:  w = a >> n;
        au_pkg::bit_asr:  w = $signed(a) >>> n;
        // Move the chosen bit to the top, then shift back arithmetically
        au_pkg::bit_sext: w = $signed(a << m) >>> m;
        default:          w = 32'd0;
      endcase
    end
    else if (op[14:12] == 3'b011)
    begin
      b      = {{24{op[11]}}, op[11:4]};
      do_add = 1'b1;
    end
    else
    begin
      b = {{23{op[12]}}, op[12:4]};
      if (op[13])
        w = b;
      else
      begin
        do_sub = 1'b1;
        res.wb = 1'b0;
      end
    end
    if (do_add)
    begin
      w  = a + b;
      ov = (a[31] == b[31]) && (w[31] != a[31]);
    end
    if (do_sub)
    begin
      w  = a - b;
      ov = (a[31] != b[31]) && (w[31] != a[31]);
    end
    res.val      = w;
    res.flg.zero = (w == 32'd0);
    res.flg.neg  = w[31];
    res.flg.ovfl = ov;
    return res;
  endfunction

  task automatic check_word(input string name, input au_pkg::word_t exp,
                            input au_pkg::word_t act);
    if (act !== exp)
    begin
      mismatch_count++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flags(input string name, input au_pkg::au_flags_t exp,
                             input au_pkg::au_flags_t act);
    if (act !== exp)
    begin
      mismatch_count++;
      $display("MISMATCH %s flags expected %b actual %b", name, exp, act);
    end
  endtask

  // Compare process, samples read data in the ACK cycle
  always @(negedge CLK)
  begin
    if (ack && !we && exp_data.size() > 0)
    begin
      cur_name     = exp_name.pop_front();
      cur_data     = exp_data.pop_front();
      cur_is_flags = exp_is_flags.pop_front();
      if (cur_is_flags)
        check_flags(cur_name, au_pkg::au_flags_t'(cur_data[2:0]),
                    au_pkg::au_flags_t'(dat_r[2:0]));
      else
        check_word(cur_name, cur_data, dat_r);
    end
  end

  task automatic bus_cycle(input logic wr, input au_pkg::wb_addr_t a,
                           input au_pkg::word_t wdata, output au_pkg::word_t rdata);
    @(posedge CLK);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= wdata;
    @(negedge CLK);
    while (!ack)
      @(negedge CLK);
    rdata = dat_r;
    @(posedge CLK);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic expect_read(input string name, input au_pkg::wb_addr_t a,
                             input au_pkg::word_t exp, input bit is_flags);
    au_pkg::word_t d;
    exp_name.push_back(name);
    exp_data.push_back(exp);
    exp_is_flags.push_back(is_flags);
    bus_cycle(1'b0, a, 32'd0, d);
  endtask

  task automatic preload(input au_pkg::slice_t s, input au_pkg::reg_addr_t r,
                         input au_pkg::word_t v);
    au_pkg::word_t d;
    ref_regs[s][r] = v;
    bus_cycle(1'b1, {au_pkg::reg_base[7:6], s, r}, v, d);
  endtask

  task automatic wait_slot_idle(input au_pkg::slice_t s);
    au_pkg::word_t d;
    int            polls;
    polls = 0;
    d     = 32'd1;
    while (d[0] && polls < 20)
    begin
      bus_cycle(1'b0, {au_pkg::slot_base[7:2], s}, 32'd0, d);
      polls++;
    end
    if (d[0])
    begin
      other_errors++;
      $display("Slot %0d still pending after %0d polls", s, polls);
    end
  endtask

  // Reference model advances in posting order, which is issue order per slice
  task automatic post_op(input au_pkg::slice_t s, input au_pkg::au_op_t op,
                         output ref_res_t res);
    au_pkg::word_t d;
    res = ref_exec(s, op);
    if (res.wb)
      ref_regs[s][res.dst] = res.val;
    ref_flags[s] = res.flg;
    bus_cycle(1'b1, {au_pkg::slot_base[7:2], s}, {17'd0, op}, d);
  endtask

  task automatic run_op(input string name, input au_pkg::slice_t s, input au_pkg::au_op_t op);
    ref_res_t res;
    post_op(s, op, res);
    wait_slot_idle(s);
    expect_read(name, {au_pkg::reg_base[7:6], s, res.dst}, ref_regs[s][res.dst], 1'b0);
    expect_read(name, {au_pkg::flag_base[7:2], s}, {29'd0, ref_flags[s]}, 1'b1);
  endtask

  task automatic check_state(input string name);
    for (int s = 0; s < au_pkg::num_slices; s++)
    begin
      for (int r = 0; r < 16; r++)
        expect_read($sformatf("%s s%0d r%0d", name, s, r),
                    {au_pkg::reg_base[7:6], au_pkg::slice_t'(s), au_pkg::reg_addr_t'(r)},
                    ref_regs[s][r], 1'b0);
      expect_read($sformatf("%s s%0d", name, s), {au_pkg::flag_base[7:2], au_pkg::slice_t'(s)},
                  {29'd0, ref_flags[s]}, 1'b1);
    end
  endtask

  initial
  begin
    au_pkg::slice_t s;
    au_pkg::au_op_t op;
    logic [31:0]    rnd;
    logic           sign;
    ref_res_t       res;
    void'($urandom(17403));
    RST   <= 1'b1;
    cyc   <= 1'b0;
    stb   <= 1'b0;
    we    <= 1'b0;
    adr   <= '0;
    dat_w <= '0;
    for (int i = 0; i < au_pkg::num_slices; i++)
      ref_flags[i] = '0;
    repeat (16) @(posedge CLK);
    RST <= 1'b0;

    // Preload every register, then overwrite some at random addresses
    for (int i = 0; i < 64; i++)
      preload(au_pkg::slice_t'(i / 16), au_pkg::reg_addr_t'(i % 16), $urandom);
    for (int i = 0; i < 32; i++)
      preload(au_pkg::slice_t'($urandom), au_pkg::reg_addr_t'($urandom), $urandom);
    check_state("preload");

    // Two-register ops, long and short form picked by bit 12
    for (int i = 0; i < n_tworeg; i++)
    begin
      rnd = $urandom;
      op  = {2'b00, rnd[12:0]};
      run_op($sformatf("tworeg %0d", i), au_pkg::slice_t'($urandom), op);
    end

    // Bit ops walk every index, with fresh data in the operand register
    for (int i = 0; i < n_bitop; i++)
    begin
      rnd = $urandom;
      s   = au_pkg::slice_t'($urandom);
      preload(s, rnd[3:0], $urandom);
      op = {3'b010, rnd[11:9], 5'(i), rnd[3:0]};
      run_op($sformatf("bitop %0d", i), s, op);
    end

    // Immediate forms, alternating the immediate sign
    for (int i = 0; i < n_imm; i++)
    begin
      rnd  = $urandom;
      s    = au_pkg::slice_t'($urandom);
      sign = i[0];
      preload(s, rnd[3:0], $urandom);
      case (i % 3)
        0:       op = {3'b011, sign, rnd[10:4], rnd[3:0]};
        1:       op = {2'b10, sign, rnd[11:4], rnd[3:0]};
        default: op = {2'b11, sign, rnd[11:4], rnd[3:0]};
      endcase
      run_op($sformatf("imm %0d", i), s, op);
    end

    // Back-to-back posts to one slot, then one post to each slot
    for (int k = 0; k < n_rounds; k++)
    begin
      s = au_pkg::slice_t'($urandom);
      post_op(s, au_pkg::au_op_t'($urandom), res);
      post_op(s, au_pkg::au_op_t'($urandom), res);
      for (int j = 0; j < au_pkg::num_slices; j++)
        post_op(au_pkg::slice_t'(j), au_pkg::au_op_t'($urandom), res);
      for (int j = 0; j < au_pkg::num_slices; j++)
        wait_slot_idle(au_pkg::slice_t'(j));
      check_state($sformatf("burst %0d", k));
    end

    repeat (2) @(posedge CLK);
    $display("Errors: %0d mismatches, %0d other", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (wd_cycles + 16) @(posedge CLK);
    $display("Timeout, run did not finish within %0d cycles", wd_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock
(
  output logic CLK
);

  // 8 ns period
  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

endmodule
